/* Bender.yml */
package:
  name: dram_user_port

sources:
  - verilog/dram_pkg.sv
  - verilog/dram_cmd_issue.sv
  - verilog/dram_wdf_issue.sv
  - verilog/dram_request_ctrl.sv
  - verilog/dram_user_port.sv
  - target: test
    files:
      - verification/dram_user_port_properties.sv
      - verification/dram_checker.sv
      - verification/dram_user_port_tb.sv

/* files.f */
verilog/dram_pkg.sv
verilog/dram_cmd_issue.sv
verilog/dram_wdf_issue.sv
verilog/dram_request_ctrl.sv
verilog/dram_user_port.sv
verification/dram_user_port_properties.sv
verification/dram_checker.sv
verification/dram_user_port_tb.sv

/* verification/dram_checker.sv */
//**************************************************************************
// DDR user port checker
// follows each accepted request, compares returned read lines with the
// expected lines and reports one line per finished request
//**************************************************************************

`timescale 1ns/1ps

module dram_checker (
    input  logic            clk,
    input  logic            rst_x_async,
    input  logic            i_init_calib_complete,
    input  logic            i_calib_done,
    input  logic            i_wr_en,
    input  logic            i_rd_en,
    input  dram_pkg::addr_t i_addr,
    input  dram_pkg::line_t i_exp_line,
    input  logic            i_busy,
    input  logic            i_rd_valid,
    input  dram_pkg::line_t i_rd_line,
    input  logic            i_app_en,
    input  logic            i_app_wdf_wren,
    output int              o_errors,
    output int              o_tests
);
    import dram_pkg::*;

    int         errors     = 0;
    int         tests      = 0;
    int         req_num    = 0;
    logic       wr_pending = 1'b0;
    logic       rd_pending = 1'b0;
    logic [1:0] calib_hist = 2'b00;
    logic       exp_calib_done;
    addr_t      req_addr;
    line_t      req_line;

    assign o_errors = errors;
    assign o_tests  = tests;

    // everything is settled by the falling edge
    always @(negedge clk) begin
        // two-flop synchronizer delay on the calibration status
        exp_calib_done = calib_hist[1];
        calib_hist     = {calib_hist[0], i_init_calib_complete};
        if (rst_x_async) begin
            if (i_calib_done !== exp_calib_done) begin
                errors++;
                $display("Error at %0t: calibration done expected %b got %b",
                         $time, exp_calib_done, i_calib_done);
            end
            if (!exp_calib_done && (!i_busy || i_app_en || i_app_wdf_wren)) begin
                errors++;
                $display("port was idle or issued to the controller before calibration at %0t",
                         $time);
            end
            // write ends when busy drops
            if (wr_pending && !i_busy) begin
                wr_pending = 1'b0;
                tests++;
                $display("request %0d: write %h done", req_num, req_addr);
            end
            if (i_rd_valid && !rd_pending) begin
                errors++;
                $display("read line returned with no read outstanding at %0t", $time);
            end else if (i_rd_valid) begin
                rd_pending = 1'b0;
                tests++;
                if (i_rd_line !== req_line) begin
                    errors++;
                    $display("Error at %0t: request %0d read %h expected %h got %h",
                             $time, req_num, req_addr, req_line, i_rd_line);
                end else begin
                    $display("request %0d: read %h ok", req_num, req_addr);
                end
            end
            // request taken at the coming edge
            if (!i_busy && (i_wr_en || i_rd_en)) begin
                req_num++;
                req_addr   = i_addr;
                req_line   = i_exp_line;
                wr_pending = i_wr_en;
                rd_pending = !i_wr_en;
            end
        end
    end

endmodule

/* verification/dram_testdata.txt */
// op addr data byte_en expected_line (lane 3 .. lane 0)
// op 1 = write, 2 = read; expected line only used by reads
2_00000000_00000000_0_00000000_00000000_00000000_00000000
1_00000104_11223344_f_00000000_00000000_00000000_00000000
2_00000100_00000000_0_00000000_00000000_11223344_00000000
1_0000010c_aabbccdd_f_00000000_00000000_00000000_00000000
2_00000108_00000000_0_aabbccdd_00000000_11223344_00000000
1_00000108_55667788_5_00000000_00000000_00000000_00000000
1_00000100_99999999_8_00000000_00000000_00000000_00000000
1_00000104_0000ee00_2_00000000_00000000_00000000_00000000
2_00000100_00000000_0_aabbccdd_00660088_1122ee44_99000000
1_00002000_cafef00d_f_00000000_00000000_00000000_00000000
1_00002004_01234567_3_00000000_00000000_00000000_00000000
1_00002008_89abcdef_c_00000000_00000000_00000000_00000000
1_0000200c_deadbeef_1_00000000_00000000_00000000_00000000
2_0000200c_00000000_0_000000ef_89ab0000_00004567_cafef00d
2_00003000_00000000_0_00000000_00000000_00000000_00000000
1_00002000_12345678_6_00000000_00000000_00000000_00000000
2_00002004_00000000_0_000000ef_89ab0000_00004567_ca34560d
2_00000100_00000000_0_aabbccdd_00660088_1122ee44_99000000
1_f0000110_77777777_f_00000000_00000000_00000000_00000000
2_00000110_00000000_0_00000000_00000000_00000000_77777777

/* verification/dram_user_port_properties.sv */
//**************************************************************************
// DDR user port assertions
// command and write data hold while stalled, busy covers every issue
//**************************************************************************

`timescale 1ns/1ps

module dram_user_port_properties (
    input logic                clk,
    input logic                rst_x_async,
    input logic                i_busy,
    input logic                i_app_en,
    input dram_pkg::app_cmd_t  i_app_cmd,
    input dram_pkg::app_addr_t i_app_addr,
    input logic                i_app_rdy,
    input logic                i_app_wdf_wren,
    input dram_pkg::line_t     i_app_wdf_data,
    input dram_pkg::wdf_mask_t i_app_wdf_mask,
    input logic                i_app_wdf_rdy
);
    int fail_count = 0;

    cmd_held: assert property (@(posedge clk) disable iff (!rst_x_async)
        (i_app_en && !i_app_rdy) |=>
            (i_app_en && $stable(i_app_cmd) && $stable(i_app_addr)))
        else begin
            fail_count++;
            $error("command changed before the controller took it");
        end

    wdf_held: assert property (@(posedge clk) disable iff (!rst_x_async)
        (i_app_wdf_wren && !i_app_wdf_rdy) |=>
            (i_app_wdf_wren && $stable(i_app_wdf_data) && $stable(i_app_wdf_mask)))
        else begin
            fail_count++;
            $error("write data changed before the controller took it");
        end

    busy_on_issue: assert property (@(posedge clk) disable iff (!rst_x_async)
        (i_app_en || i_app_wdf_wren) |-> i_busy)
        else begin
            fail_count++;
            $error("controller request outstanding while the port is idle");
        end

endmodule

/* verification/dram_user_port_tb.sv */
//**************************************************************************
// DDR user port testbench
// replays the requests of the testdata file, models the DDR controller
// with a line memory and random ready back-pressure, and bounds the run
//**************************************************************************

`timescale 1ns/1ps

module dram_user_port_tb;
    import dram_pkg::*;

    localparam int         MAX_REQS = 64;
    localparam logic [3:0] OP_WRITE = 4'h1;
    localparam logic [3:0] OP_READ  = 4'h2;

    logic       clk;
    logic       rst_x_async;
    logic       wr_en;
    logic       rd_en;
    addr_t      addr;
    word_t      data;
    byte_en_t   byte_en;
    line_t      exp_line;
    logic       busy;
    logic       calib_done;
    logic       rd_valid;
    line_t      rd_line;
    logic       init_calib;
    logic       app_en;
    app_cmd_t   app_cmd;
    app_addr_t  app_addr;
    logic       app_rdy;
    logic       app_wdf_wren;
    line_t      app_wdf_data;
    wdf_mask_t  app_wdf_mask;
    logic       app_wdf_rdy;
    logic       app_rd_data_valid;
    line_t      app_rd_data;

    // op, address, data, byte enables, expected line
    logic [199:0] reqs [0:MAX_REQS-1];
    int           num_reqs;
    int           timeout_limit = 0;
    int           cycles = 0;
    int           check_errors;
    int           check_tests;
    int           total_errors;

    // controller model state
    line_t     mem [app_addr_t];
    app_addr_t wr_addr;
    line_t     wr_data;
    wdf_mask_t wr_mask;
    logic      wr_addr_ok = 1'b0;
    logic      wr_data_ok = 1'b0;
    app_addr_t rd_addr;
    int        rd_wait = 0;

    dram_user_port #(
        .CALIB_SYNC_STAGES (2)
    ) dram_user_port_inst (
        .clk                   (clk),
        .rst_x_async           (rst_x_async),
        .i_wr_en               (wr_en),
        .i_rd_en               (rd_en),
        .i_addr                (addr),
        .i_data                (data),
        .i_byte_en             (byte_en),
        .o_busy                (busy),
        .o_calib_done          (calib_done),
        .o_rd_valid            (rd_valid),
        .o_rd_line             (rd_line),
        .i_init_calib_complete (init_calib),
        .o_app_en              (app_en),
        .o_app_cmd             (app_cmd),
        .o_app_addr            (app_addr),
        .i_app_rdy             (app_rdy),
        .o_app_wdf_wren        (app_wdf_wren),
        .o_app_wdf_data        (app_wdf_data),
        .o_app_wdf_mask        (app_wdf_mask),
        .i_app_wdf_rdy         (app_wdf_rdy),
        .i_app_rd_data_valid   (app_rd_data_valid),
        .i_app_rd_data         (app_rd_data)
    );

    bind dram_user_port dram_user_port_properties props_inst (
        .clk              (clk),
        .rst_x_async      (rst_x_async),
        .i_busy           (o_busy),
        .i_app_en         (o_app_en),
        .i_app_cmd        (o_app_cmd),
        .i_app_addr       (o_app_addr),
        .i_app_rdy        (i_app_rdy),
        .i_app_wdf_wren   (o_app_wdf_wren),
        .i_app_wdf_data   (o_app_wdf_data),
        .i_app_wdf_mask   (o_app_wdf_mask),
        .i_app_wdf_rdy    (i_app_wdf_rdy)
    );

    dram_checker check_inst (
        .clk                   (clk),
        .rst_x_async           (rst_x_async),
        .i_init_calib_complete (init_calib),
        .i_calib_done          (calib_done),
        .i_wr_en               (wr_en),
        .i_rd_en               (rd_en),
        .i_addr                (addr),
        .i_exp_line            (exp_line),
        .i_busy                (busy),
        .i_rd_valid            (rd_valid),
        .i_rd_line             (rd_line),
        .i_app_en              (app_en),
        .i_app_wdf_wren        (app_wdf_wren),
        .o_errors              (check_errors),
        .o_tests               (check_tests)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // masked line write, mask bit set means byte kept
    function automatic line_t merge_line(line_t old_line, line_t wdata, wdf_mask_t mask);
        line_t result;
        result = old_line;
        for (int b = 0; b < 16; b++) begin
            if (!mask[b]) begin
                result[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return result;
    endfunction

    function automatic line_t stored_line(app_addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return '0;
    endfunction

    // controller side acceptances, seen mid-cycle
    always @(negedge clk) begin
        if (app_en && app_rdy) begin
            if (app_cmd == CMD_READ) begin
                rd_addr = app_addr;
                rd_wait = 3;
            end else begin
                wr_addr    = app_addr;
                wr_addr_ok = 1'b1;
            end
        end
        if (app_wdf_wren && app_wdf_rdy) begin
            wr_data    = app_wdf_data;
            wr_mask    = app_wdf_mask;
            wr_data_ok = 1'b1;
        end
        if (wr_addr_ok && wr_data_ok) begin
            mem[wr_addr] = merge_line(stored_line(wr_addr), wr_data, wr_mask);
            wr_addr_ok   = 1'b0;
            wr_data_ok   = 1'b0;
        end
    end

    // ready back-pressure and read return
    initial begin
        void'($urandom(32'haf548934));
        app_rdy           = 1'b0;
        app_wdf_rdy       = 1'b0;
        app_rd_data_valid = 1'b0;
        app_rd_data       = '0;
        forever begin
            @(posedge clk);
            #2;
            app_rdy           = ($urandom % 4) != 0;
            app_wdf_rdy       = ($urandom % 4) != 0;
            app_rd_data_valid = 1'b0;
            if (rd_wait > 0) begin
                rd_wait--;
                if (rd_wait == 0) begin
                    app_rd_data_valid = 1'b1;
                    app_rd_data       = stored_line(rd_addr);
                end
            end
        end
    end

    // waits for an idle port, then presents one request for a single cycle
    task automatic issue_request(input int idx);
        logic [199:0] rec;
        rec = reqs[idx];
        while (busy) begin
            @(posedge clk);
            #2;
        end
        wr_en    = (rec[199:196] == OP_WRITE);
        rd_en    = (rec[199:196] == OP_READ);
        addr     = rec[195:164];
        data     = rec[163:132];
        byte_en  = rec[131:128];
        exp_line = rec[127:0];
        @(posedge clk);
        #2;
        wr_en = 1'b0;
        rd_en = 1'b0;
    endtask

    initial begin
        while ((timeout_limit == 0) || (cycles < timeout_limit)) begin
            @(posedge clk);
            cycles++;
        end
        $display("run stopped after %0d cycles without finishing", cycles);
        $display("test failed");
        $finish;
    end

    initial begin
        rst_x_async = 1'b0;
        init_calib  = 1'b0;
        wr_en       = 1'b0;
        rd_en       = 1'b0;
        addr        = '0;
        data        = '0;
        byte_en     = '0;
        exp_line    = '0;
        for (int i = 0; i < MAX_REQS; i++) begin
            reqs[i] = '0;
        end
        $readmemh("verification/dram_testdata.txt", reqs);
        num_reqs = 0;
        while ((num_reqs < MAX_REQS) && (reqs[num_reqs][199:196] != 4'h0)) begin
            num_reqs++;
        end
        timeout_limit = num_reqs * 40 + 100;
        repeat (4) @(posedge clk);
        #2;
        rst_x_async = 1'b1;
        // a write held up during calibration must not reach the controller
        repeat (2) @(posedge clk);
        #2;
        wr_en   = 1'b1;
        addr    = 32'h0000_0000;
        data    = 32'h5a5a_5a5a;
        byte_en = 4'hf;
        repeat (6) @(posedge clk);
        #2;
        wr_en   = 1'b0;
        byte_en = '0;
        repeat (2) @(posedge clk);
        #2;
        init_calib = 1'b1;
        for (int i = 0; i < num_reqs; i++) begin
            issue_request(i);
        end
        while (busy) begin
            @(posedge clk);
            #2;
        end
        // one more cycle so the checker sees the last completion
        @(posedge clk);
        #2;
        total_errors = check_errors + dram_user_port_inst.props_inst.fail_count;
        $display("%0d of %0d requests completed, %0d errors",
                 check_tests, num_reqs, total_errors);
        if ((total_errors == 0) && (check_tests == num_reqs)) begin
            $display("test passed");
        end else begin
            if (check_tests != num_reqs) begin
                $display("not every request completed");
            end
            $display("test failed");
        end
        $finish;
    end

endmodule

/* verilog/dram_cmd_issue.sv */
//**************************************************************************
// DDR command issuer
// registers the command code and line address of one request and holds
// app_en until the controller signals app_rdy
//**************************************************************************

`timescale 1ns/1ps

module dram_cmd_issue (
    input  logic                clk,
    input  logic                rst_x_async,
    input  logic                i_start,
    input  logic                i_is_write,
    input  dram_pkg::addr_t     i_addr,
    input  logic                i_app_rdy,
    output logic                o_app_en,
    output dram_pkg::app_cmd_t  o_app_cmd,
    output dram_pkg::app_addr_t o_app_addr,
    output logic                o_done
);
    import dram_pkg::*;

    logic accepted;

    // command taken by the controller this cycle
    assign accepted = o_app_en && i_app_rdy;

    // enable stays up until the handshake completes
    always_ff @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            o_app_en <= 1'b0;
        end else if (i_start) begin
            o_app_en <= 1'b1;
        end else if (accepted) begin
            o_app_en <= 1'b0;
        end
    end

    // command and line address, held while waiting for app_rdy
    always_ff @(posedge clk) begin
        if (i_start) begin
            if (i_is_write) begin
                o_app_cmd <= CMD_WRITE;
            end else begin
                o_app_cmd <= CMD_READ;
            end
            // 128-bit line address, low three bits zero
            o_app_addr <= {1'b0, i_addr[27:4], 3'b000};
        end
    end

    // one-cycle completion at acceptance
    assign o_done = accepted;

endmodule

/* verilog/dram_pkg.sv */
//**************************************************************************
// DDR user port shared definitions
// widths of the user word, the DDR line and the controller command,
// plus the request state encoding used by the front end
//**************************************************************************

package dram_pkg;

    // user side
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  byte_en_t;

    // controller application side
    typedef logic [27:0]  app_addr_t;
    typedef logic [127:0] line_t;
    // 1 = byte not written
    typedef logic [15:0]  wdf_mask_t;
    typedef logic [2:0]   app_cmd_t;

    localparam app_cmd_t CMD_WRITE = 3'b000;
    localparam app_cmd_t CMD_READ  = 3'b001;

    // 32-bit lanes per DDR line
    localparam int LANES = 4;

    // request state machine
    typedef enum logic [1:0] {
        CALIB = 2'b00,
        IDLE  = 2'b01,
        WRITE = 2'b10,
        READ  = 2'b11
    } req_state_t;

endpackage

/* verilog/dram_request_ctrl.sv */
//**************************************************************************
// DDR request controller
// waits for calibration, takes one user request at a time, starts the
// command and write data issuers, and ends a write once both have been
// accepted or a read once the line has come back
//**************************************************************************

`timescale 1ns/1ps

module dram_request_ctrl #(
    parameter int CALIB_SYNC_STAGES = 2
) (
    input  logic            clk,
    input  logic            rst_x_async,
    input  logic            i_init_calib_complete,
    input  logic            i_wr_en,
    input  logic            i_rd_en,
    input  logic            i_cmd_done,
    input  logic            i_wdf_done,
    input  logic            i_app_rd_data_valid,
    input  dram_pkg::line_t i_app_rd_data,
    output logic            o_busy,
    output logic            o_calib_done,
    output logic            o_start_cmd,
    output logic            o_start_wdf,
    output logic            o_is_write,
    output logic            o_rd_valid,
    output dram_pkg::line_t o_rd_line
);
    import dram_pkg::*;

    logic [CALIB_SYNC_STAGES-1:0] calib_sync;
    req_state_t                   state;
    req_state_t                   state_next;
    logic                         accept;
    logic                         cmd_seen;
    logic                         wdf_seen;
    logic                         cmd_ok;
    logic                         wdf_ok;
    logic                         write_end;
    logic                         read_end;

    // calibration status comes from another domain
    always_ff @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            calib_sync <= '0;
        end else begin
            calib_sync[0] <= i_init_calib_complete;
            for (int i = 1; i < CALIB_SYNC_STAGES; i++) begin
                calib_sync[i] <= calib_sync[i-1];
            end
        end
    end

    assign o_calib_done = calib_sync[CALIB_SYNC_STAGES-1];

    // request taken from the core, write has priority
    assign accept      = (state == IDLE) && (i_wr_en || i_rd_en);
    assign o_start_cmd = accept;
    assign o_start_wdf = accept && i_wr_en;
    assign o_is_write  = i_wr_en;

    // acceptances seen now or in an earlier cycle
    assign cmd_ok    = cmd_seen || i_cmd_done;
    assign wdf_ok    = wdf_seen || i_wdf_done;
    assign write_end = (state == WRITE) && cmd_ok && wdf_ok;
    assign read_end  = (state == READ) && i_app_rd_data_valid;

    always_comb begin
        state_next = state;
        case (state)
            CALIB: begin
                if (o_calib_done) begin
                    state_next = IDLE;
                end
            end
            IDLE: begin
                if (i_wr_en) begin
                    state_next = WRITE;
                end else if (i_rd_en) begin
                    state_next = READ;
                end
            end
            WRITE: begin
                if (write_end) begin
                    state_next = IDLE;
                end
            end
            READ: begin
                if (read_end) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = CALIB;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            state <= CALIB;
        end else begin
            state <= state_next;
        end
    end

    // command and write data may finish in either order
    always_ff @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            cmd_seen <= 1'b0;
            wdf_seen <= 1'b0;
        end else if ((state == WRITE) && !write_end) begin
            cmd_seen <= cmd_ok;
            wdf_seen <= wdf_ok;
        end else begin
            cmd_seen <= 1'b0;
            wdf_seen <= 1'b0;
        end
    end

    // read line pulse, one per read request
    always_ff @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            o_rd_valid <= 1'b0;
        end else begin
            o_rd_valid <= read_end;
        end
    end

    always_ff @(posedge clk) begin
        if (read_end) begin
            o_rd_line <= i_app_rd_data;
        end
    end

    assign o_busy = (state != IDLE);

endmodule

/* verilog/dram_user_port.sv */
//**************************************************************************
// DDR user port front end
// single-clock bridge from a 32-bit core request port to the 128-bit
// application port of a DDR controller, built from a request controller,
// a command issuer and a write data issuer
//**************************************************************************

`timescale 1ns/1ps

module dram_user_port #(
    parameter int CALIB_SYNC_STAGES = 2
) (
    input  logic                clk,
    input  logic                rst_x_async,
    // core side
    input  logic                i_wr_en,
    input  logic                i_rd_en,
    input  dram_pkg::addr_t     i_addr,
    input  dram_pkg::word_t     i_data,
    input  dram_pkg::byte_en_t  i_byte_en,
    output logic                o_busy,
    output logic                o_calib_done,
    output logic                o_rd_valid,
    output dram_pkg::line_t     o_rd_line,
    // controller side
    input  logic                i_init_calib_complete,
    output logic                o_app_en,
    output dram_pkg::app_cmd_t  o_app_cmd,
    output dram_pkg::app_addr_t o_app_addr,
    input  logic                i_app_rdy,
    output logic                o_app_wdf_wren,
    output dram_pkg::line_t     o_app_wdf_data,
    output dram_pkg::wdf_mask_t o_app_wdf_mask,
    input  logic                i_app_wdf_rdy,
    input  logic                i_app_rd_data_valid,
    input  dram_pkg::line_t     i_app_rd_data
);

    logic       start_cmd;
    logic       start_wdf;
    logic       is_write;
    logic       cmd_done;
    logic       wdf_done;
    logic [1:0] lane;

    // 32-bit lane inside the 128-bit line
    assign lane = i_addr[3:2];

    dram_request_ctrl #(
        .CALIB_SYNC_STAGES (CALIB_SYNC_STAGES)
    ) u_request_ctrl (
        .clk                   (clk),
        .rst_x_async           (rst_x_async),
        .i_init_calib_complete (i_init_calib_complete),
        .i_wr_en               (i_wr_en),
        .i_rd_en               (i_rd_en),
        .i_cmd_done            (cmd_done),
        .i_wdf_done            (wdf_done),
        .i_app_rd_data_valid   (i_app_rd_data_valid),
        .i_app_rd_data         (i_app_rd_data),
        .o_busy                (o_busy),
        .o_calib_done          (o_calib_done),
        .o_start_cmd           (start_cmd),
        .o_start_wdf           (start_wdf),
        .o_is_write            (is_write),
        .o_rd_valid            (o_rd_valid),
        .o_rd_line             (o_rd_line)
    );

    dram_cmd_issue u_cmd_issue (
        .clk         (clk),
        .rst_x_async (rst_x_async),
        .i_start     (start_cmd),
        .i_is_write  (is_write),
        .i_addr      (i_addr),
        .i_app_rdy   (i_app_rdy),
        .o_app_en    (o_app_en),
        .o_app_cmd   (o_app_cmd),
        .o_app_addr  (o_app_addr),
        .o_done      (cmd_done)
    );

    // started on writes only
    dram_wdf_issue u_wdf_issue (
        .clk            (clk),
        .rst_x_async    (rst_x_async),
        .i_start        (start_wdf),
        .i_lane         (lane),
        .i_data         (i_data),
        .i_byte_en      (i_byte_en),
        .i_app_wdf_rdy  (i_app_wdf_rdy),
        .o_app_wdf_wren (o_app_wdf_wren),
        .o_app_wdf_data (o_app_wdf_data),
        .o_app_wdf_mask (o_app_wdf_mask),
        .o_done         (wdf_done)
    );

endmodule

/* verilog/dram_wdf_issue.sv */
//**************************************************************************
// DDR write data issuer
// places the user word and byte enables in their lane of a 128-bit line
// and holds app_wdf_wren until the controller signals app_wdf_rdy
//**************************************************************************

`timescale 1ns/1ps

module dram_wdf_issue (
    input  logic                clk,
    input  logic                rst_x_async,
    input  logic                i_start,
    input  logic [1:0]          i_lane,
    input  dram_pkg::word_t     i_data,
    input  dram_pkg::byte_en_t  i_byte_en,
    input  logic                i_app_wdf_rdy,
    output logic                o_app_wdf_wren,
    output dram_pkg::line_t     o_app_wdf_data,
    output dram_pkg::wdf_mask_t o_app_wdf_mask,
    output logic                o_done
);
    import dram_pkg::*;

    wdf_mask_t lane_en;
    wdf_mask_t line_mask;
    line_t     line_data;
    logic      accepted;

    // word copied to every lane, the mask picks the one that counts
    assign line_data = {LANES{i_data}};

    // byte enables moved up to the selected lane
    assign lane_en   = {12'b0, i_byte_en} << {i_lane, 2'b00};

    // controller mask is active high, so unselected bytes are masked
    assign line_mask = ~lane_en;

    assign accepted  = o_app_wdf_wren && i_app_wdf_rdy;

    // write enable held until the data is taken
    always_ff @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            o_app_wdf_wren <= 1'b0;
        end else if (i_start) begin
            o_app_wdf_wren <= 1'b1;
        end else if (accepted) begin
            o_app_wdf_wren <= 1'b0;
        end
    end

    // line data and mask
    always_ff @(posedge clk) begin
        if (i_start) begin
            o_app_wdf_data <= line_data;
            o_app_wdf_mask <= line_mask;
        end
    end

    assign o_done = accepted;

endmodule
